// File: src/kbd_cfg.svh
// Keyboard configuration defines

`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

//----------------------------------------------------------------------
// Auto-repeat timing in CLK_14M cycles
//----------------------------------------------------------------------

// Hold time before the first repeat, about 0.5 s
`define KBD_REPEAT_FIRST 23'd7000000

// Spacing of later repeats, about 1/15 s
`define KBD_REPEAT_NEXT 23'd933333

//----------------------------------------------------------------------
// Decoded PS/2 event word fields
//----------------------------------------------------------------------

`define KBD_TOGGLE_BIT 10   // Flips once per event

`define KBD_MAKE_BIT 9      // 1 make, 0 break

`define KBD_EXT_BIT 8       // E0 prefix seen

`endif

// File: src/kbd_pkg.sv
// Keyboard types and scancodes

`default_nettype none

package kbd_pkg;

    // Sequencer states, encoded 0 to 8
    typedef enum logic [3:0] {
        idle       = 4'd0,
        have_code  = 4'd1,
        decode     = 4'd2,
        got_break  = 4'd3,
        break2     = 4'd4,
        key_up     = 4'd5,
        normal_key = 4'd6,
        key_ready1 = 4'd7,
        key_ready  = 4'd8
    } kbd_state_t;

    // PS/2 set 2 scancode
    typedef logic [7:0] scancode_t;

    //------------------------------------------------------------------
    // Modifier keys
    //------------------------------------------------------------------
    localparam scancode_t SC_LSHIFT = 8'h12;
    localparam scancode_t SC_RSHIFT = 8'h59;
    localparam scancode_t SC_LCTRL  = 8'h14;
    localparam scancode_t SC_CAPS   = 8'h58;
    localparam scancode_t SC_WIN    = 8'h1F;   // Open Apple
    localparam scancode_t SC_ALT    = 8'h11;   // Closed Apple

endpackage

`default_nettype wire

// File: src/kbd_sequencer.sv
// PS/2 event sequencer

`timescale 1ns/1ps
`default_nettype none

`include "kbd_cfg.svh"

module kbd_sequencer
    import kbd_pkg::*;
(
    input  wire         CLK_14M,
    input  wire         reset,
    input  wire  [10:0] ps2_key,
    input  wire         is_modifier,
    input  wire         char_valid,
    input  wire         expire,
    input  wire         reads,
    output logic        mod_make,
    output logic        mod_break,
    output logic        latch_key,
    output logic        arm,
    output logic        run,
    output logic        akd,
    output logic        key_pressed
);

    kbd_state_t state;
    kbd_state_t next_state;
    logic       old_toggle;     // Toggle value of the last accepted event
    logic       toggle;
    logic       make;

    assign toggle = ps2_key[`KBD_TOGGLE_BIT];
    assign make   = ps2_key[`KBD_MAKE_BIT];

    //------------------------------------------------------------------
    // Decode sequence
    //------------------------------------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (toggle != old_toggle)
                    next_state = have_code;
            end
            have_code:  next_state = decode;
            decode:
            begin
                if (!make)
                    next_state = got_break;
                else if (is_modifier)
                    next_state = idle;      // Modifiers make no character
                else
                    next_state = normal_key;
            end
            got_break:  next_state = break2;
            break2:     next_state = key_up;
            key_up:     next_state = idle;
            normal_key: next_state = key_ready1;
            key_ready1: next_state = key_ready;
            key_ready:  next_state = idle;
            default:    next_state = idle;
        endcase
    end

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            state      <= idle;
            old_toggle <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == have_code)
                old_toggle <= toggle;
        end
    end

    // Pulses to the modifier and translation blocks
    assign mod_make  = (state == have_code) && make;
    assign mod_break = (state == key_up);
    assign latch_key = (state == normal_key);
    assign arm       = (state == key_ready) && char_valid;

    //------------------------------------------------------------------
    // Strobe and any-key-down
    //------------------------------------------------------------------
    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            key_pressed <= 1'b0;
            akd         <= 1'b0;
        end
        else
        begin
            if (reads)
                key_pressed <= 1'b0;
            if (arm)
            begin
                key_pressed <= 1'b1;
                akd         <= 1'b1;
            end
            else if (expire)
                key_pressed <= 1'b1;            // Auto-repeat strobe
            if (state == got_break)
                akd <= 1'b0;                    // Any break ends the hold
        end
    end

    // Repeat only counts once the last strobe was read
    assign run = akd && !key_pressed;

    a_state_legal: assert property (@(posedge CLK_14M) disable iff (reset)
        state inside {idle, have_code, decode, got_break, break2, key_up,
                      normal_key, key_ready1, key_ready})
        else $error("sequencer state out of range");

    // The event word is read live until the decode is finished
    a_event_steady: assert property (@(posedge CLK_14M) disable iff (reset)
        (state != idle) |-> $stable(ps2_key))
        else $error("event word changed during decode");

endmodule

`default_nettype wire

// File: src/repeat_timer.sv
// Auto-repeat down counter

`timescale 1ns/1ps
`default_nettype none

`include "kbd_cfg.svh"

module repeat_timer #(
    parameter logic [22:0] FIRST_DELAY = `KBD_REPEAT_FIRST,
    parameter logic [22:0] NEXT_DELAY  = `KBD_REPEAT_NEXT
)(
    input  wire  CLK_14M,
    input  wire  reset,
    input  wire  arm,
    input  wire  run,
    output logic expire
);

    logic [22:0] count;

    // Zero reached while counting, and no new key loading
    assign expire = run && !arm && (count == '0);

    //------------------------------------------------------------------
    // Reloadable counter
    //------------------------------------------------------------------
    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (arm)
            count <= FIRST_DELAY;               // New key restarts the hold delay
        else if (run)
        begin
            if (count == '0)
                count <= NEXT_DELAY;            // Typematic rate from here on
            else
                count <= count - 23'd1;
        end
    end

    a_expire_needs_run: assert property (@(posedge CLK_14M) disable iff (reset)
        expire |-> run)
        else $error("repeat expiry while paused");

endmodule

`default_nettype wire

// File: src/modifier_track.sv
// Modifier key tracking

`timescale 1ns/1ps
`default_nettype none

module modifier_track
    import kbd_pkg::*;
(
    input  wire       CLK_14M,
    input  wire       reset,
    input  scancode_t code,
    input  wire       mod_make,
    input  wire       mod_break,
    output logic      is_modifier,
    output logic      shift,
    output logic      ctrl,
    output logic      caps,
    output logic      open_apple,
    output logic      closed_apple
);

    // Apple keys still go on to translation
    assign is_modifier = (code == SC_LSHIFT) || (code == SC_RSHIFT) ||
                         (code == SC_LCTRL)  || (code == SC_CAPS);

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            shift        <= 1'b0;
            ctrl         <= 1'b0;
            caps         <= 1'b0;
            open_apple   <= 1'b0;
            closed_apple <= 1'b0;
        end
        else if (mod_make)
        begin
            case (code)
                SC_LSHIFT, SC_RSHIFT: shift        <= 1'b1;
                SC_LCTRL:             ctrl         <= 1'b1;
                SC_WIN:               open_apple   <= 1'b1;
                SC_ALT:               closed_apple <= 1'b1;
                default:              ;
            endcase
        end
        else if (mod_break)
        begin
            case (code)
                SC_LSHIFT, SC_RSHIFT: shift        <= 1'b0;
                SC_LCTRL:             ctrl         <= 1'b0;
                SC_CAPS:              caps         <= ~caps;    // Flips on release
                SC_WIN:               open_apple   <= 1'b0;
                SC_ALT:               closed_apple <= 1'b0;
                default:              ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/scan_to_ascii.sv
// Scancode to Apple ASCII translator

`timescale 1ns/1ps
`default_nettype none

module scan_to_ascii
    import kbd_pkg::*;
(
    input  wire        CLK_14M,
    input  wire        reset,
    input  scancode_t  code,
    input  wire        ext,
    input  wire        latch_key,
    input  wire        shift,
    input  wire        ctrl,
    input  wire        caps,
    output logic [6:0] ascii,
    output logic       char_valid
);

    scancode_t  key_code;       // Latched key
    logic       key_ext;
    logic       convert;        // Table output settles one cycle after latch
    logic [6:0] lo_char;
    logic [6:0] hi_char;
    logic       known;
    logic       letter;
    logic [6:0] next_char;

    //------------------------------------------------------------------
    // Character table, unshifted and shifted
    //------------------------------------------------------------------
    always_comb
    begin
        lo_char = 7'h00;
        hi_char = 7'h00;
        known   = 1'b1;
        case ({key_ext, key_code})
            // Letters, upper case is derived below
            9'h01C: lo_char = 7'h61;    // a
            9'h032: lo_char = 7'h62;
            9'h021: lo_char = 7'h63;
            9'h023: lo_char = 7'h64;
            9'h024: lo_char = 7'h65;
            9'h02B: lo_char = 7'h66;
            9'h034: lo_char = 7'h67;
            9'h033: lo_char = 7'h68;
            9'h043: lo_char = 7'h69;
            9'h03B: lo_char = 7'h6A;
            9'h042: lo_char = 7'h6B;
            9'h04B: lo_char = 7'h6C;
            9'h03A: lo_char = 7'h6D;
            9'h031: lo_char = 7'h6E;
            9'h044: lo_char = 7'h6F;
            9'h04D: lo_char = 7'h70;
            9'h015: lo_char = 7'h71;
            9'h02D: lo_char = 7'h72;
            9'h01B: lo_char = 7'h73;
            9'h02C: lo_char = 7'h74;
            9'h03C: lo_char = 7'h75;
            9'h02A: lo_char = 7'h76;
            9'h01D: lo_char = 7'h77;
            9'h022: lo_char = 7'h78;
            9'h035: lo_char = 7'h79;
            9'h01A: lo_char = 7'h7A;    // z
            // Digit row
            9'h016: {lo_char, hi_char} = {7'h31, 7'h21};
            9'h01E: {lo_char, hi_char} = {7'h32, 7'h40};
            9'h026: {lo_char, hi_char} = {7'h33, 7'h23};
            9'h025: {lo_char, hi_char} = {7'h34, 7'h24};
            9'h02E: {lo_char, hi_char} = {7'h35, 7'h25};
            9'h036: {lo_char, hi_char} = {7'h36, 7'h5E};
            9'h03D: {lo_char, hi_char} = {7'h37, 7'h26};
            9'h03E: {lo_char, hi_char} = {7'h38, 7'h2A};
            9'h046: {lo_char, hi_char} = {7'h39, 7'h28};
            9'h045: {lo_char, hi_char} = {7'h30, 7'h29};
            // Punctuation
            9'h04E: {lo_char, hi_char} = {7'h2D, 7'h5F};    // - _
            9'h055: {lo_char, hi_char} = {7'h3D, 7'h2B};    // = +
            9'h054: {lo_char, hi_char} = {7'h5B, 7'h7B};
            9'h05B: {lo_char, hi_char} = {7'h5D, 7'h7D};
            9'h05D: {lo_char, hi_char} = {7'h5C, 7'h7C};
            9'h04C: {lo_char, hi_char} = {7'h3B, 7'h3A};    // ; :
            9'h052: {lo_char, hi_char} = {7'h27, 7'h22};
            9'h041: {lo_char, hi_char} = {7'h2C, 7'h3C};
            9'h049: {lo_char, hi_char} = {7'h2E, 7'h3E};
            9'h04A: {lo_char, hi_char} = {7'h2F, 7'h3F};    // / ?
            9'h00E: {lo_char, hi_char} = {7'h60, 7'h7E};
            // Control keys, unaffected by shift
            9'h029: {lo_char, hi_char} = {7'h20, 7'h20};    // Space
            9'h05A: {lo_char, hi_char} = {7'h0D, 7'h0D};    // Return
            9'h076: {lo_char, hi_char} = {7'h1B, 7'h1B};    // Escape
            9'h066: {lo_char, hi_char} = {7'h08, 7'h08};    // Backspace acts as left
            // Extended arrows
            9'h16B: {lo_char, hi_char} = {7'h08, 7'h08};
            9'h174: {lo_char, hi_char} = {7'h15, 7'h15};
            9'h175: {lo_char, hi_char} = {7'h0B, 7'h0B};
            9'h172: {lo_char, hi_char} = {7'h0A, 7'h0A};
            default: known = 1'b0;
        endcase
    end

    assign letter = (lo_char >= 7'h61) && (lo_char <= 7'h7A);

    // Modifier rules
    always_comb
    begin
        if (letter && ctrl)
            next_char = lo_char - 7'h60;        // Control code, 01 to 1A
        else if (letter && (caps || shift))
            next_char = lo_char - 7'h20;
        else if (shift)
            next_char = hi_char;
        else
            next_char = lo_char;
    end

    //------------------------------------------------------------------
    // Latch and result registers
    //------------------------------------------------------------------
    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            key_code   <= '0;
            key_ext    <= 1'b0;
            convert    <= 1'b0;
            ascii      <= 7'h00;
            char_valid <= 1'b0;
        end
        else
        begin
            convert <= latch_key;
            if (latch_key)
            begin
                key_code <= code;
                key_ext  <= ext;
            end
            if (convert)
            begin
                char_valid <= known;
                ascii      <= known ? next_char : 7'h00;
            end
        end
    end

    a_table_sane: assert property (@(posedge CLK_14M) disable iff (reset)
        !(ascii[6] && ascii[5] && !char_valid))
        else $error("lower-case range character without a valid key");

endmodule

`default_nettype wire

// File: src/apple_keyboard.sv
// Apple IIe keyboard front end

`timescale 1ns/1ps
`default_nettype none

`include "kbd_cfg.svh"

module apple_keyboard
    import kbd_pkg::*;
#(
    parameter logic [22:0] FIRST_DELAY = `KBD_REPEAT_FIRST,
    parameter logic [22:0] NEXT_DELAY  = `KBD_REPEAT_NEXT
)(
    input  wire         CLK_14M,
    input  wire         reset,
    input  wire  [10:0] ps2_key,
    input  wire         reads,
    output logic        akd,
    output logic [7:0]  k,
    output logic        open_apple,
    output logic        closed_apple
);

    scancode_t  key_code;
    logic       mod_make;
    logic       mod_break;
    logic       latch_key;
    logic       arm;
    logic       run;
    logic       expire;
    logic       is_modifier;
    logic       char_valid;
    logic       shift;
    logic       ctrl;
    logic       caps;
    logic       key_pressed;
    logic [6:0] ascii;

    assign key_code = ps2_key[7:0];
    assign k        = {key_pressed, ascii};     // Strobe in bit 7

    kbd_sequencer u_sequencer (
        .CLK_14M     (CLK_14M),
        .reset       (reset),
        .ps2_key     (ps2_key),
        .is_modifier (is_modifier),
        .char_valid  (char_valid),
        .expire      (expire),
        .reads       (reads),
        .mod_make    (mod_make),
        .mod_break   (mod_break),
        .latch_key   (latch_key),
        .arm         (arm),
        .run         (run),
        .akd         (akd),
        .key_pressed (key_pressed)
    );

    repeat_timer #(
        .FIRST_DELAY (FIRST_DELAY),
        .NEXT_DELAY  (NEXT_DELAY)
    ) u_repeat (
        .CLK_14M (CLK_14M),
        .reset   (reset),
        .arm     (arm),
        .run     (run),
        .expire  (expire)
    );

    modifier_track u_modifiers (
        .CLK_14M      (CLK_14M),
        .reset        (reset),
        .code         (key_code),
        .mod_make     (mod_make),
        .mod_break    (mod_break),
        .is_modifier  (is_modifier),
        .shift        (shift),
        .ctrl         (ctrl),
        .caps         (caps),
        .open_apple   (open_apple),
        .closed_apple (closed_apple)
    );

    scan_to_ascii u_translate (
        .CLK_14M    (CLK_14M),
        .reset      (reset),
        .code       (key_code),
        .ext        (ps2_key[`KBD_EXT_BIT]),
        .latch_key  (latch_key),
        .shift      (shift),
        .ctrl       (ctrl),
        .caps       (caps),
        .ascii      (ascii),
        .char_valid (char_valid)
    );

endmodule

`default_nettype wire

// File: tests/tb_apple_keyboard.sv
// Apple keyboard testbench

`timescale 1ns/1ps
`default_nettype none

`include "kbd_cfg.svh"

module tb_apple_keyboard
    import kbd_pkg::*;
();

    localparam int STIM_DEPTH = 128;
    localparam int WAIT_LIMIT = 200;    // Covers a full first delay

    logic        CLK_14M;
    logic        reset;
    logic [10:0] ps2_key;
    logic        reads;
    wire         akd;
    wire  [7:0]  k;
    wire         open_apple;
    wire         closed_apple;

    logic [15:0] stim_mem [0:STIM_DEPTH-1];
    int          errors;
    int          checks;
    integer      seed;

    apple_keyboard #(
        .FIRST_DELAY (23'd40),
        .NEXT_DELAY  (23'd12)
    ) dut (
        .CLK_14M      (CLK_14M),
        .reset        (reset),
        .ps2_key      (ps2_key),
        .reads        (reads),
        .akd          (akd),
        .k            (k),
        .open_apple   (open_apple),
        .closed_apple (closed_apple)
    );

    initial
    begin
        CLK_14M = 1'b0;
        forever #20 CLK_14M = ~CLK_14M;     // 40 ns period
    end

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    task automatic check_value(input logic [7:0] got, input logic [7:0] expected,
                               input string what);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        kbd_state_t seen;
        seen = dut.u_sequencer.state;
        errors++;
        $display("Timed out at %0t waiting for %s, sequencer in %s", $time, what, seen.name());
    endtask

    // Sequencer leaves idle, then comes back when the event is done
    task automatic wait_decode();
        int n;
        bit busy;
        busy = 1'b0;
        for (n = 0; n < 8 && !busy; n++)
        begin
            @(negedge CLK_14M);
            busy = (dut.u_sequencer.state != idle);
        end
        if (!busy)
            report_timeout("the sequencer to take the event");
        else
        begin
            for (n = 0; n < 16 && busy; n++)
            begin
                @(negedge CLK_14M);
                busy = (dut.u_sequencer.state != idle);
            end
            if (busy)
                report_timeout("the sequencer to return to idle");
        end
    endtask

    task automatic send_event(input logic make, input logic ext, input logic [7:0] code);
        int gap;
        @(posedge CLK_14M);
        #2;
        ps2_key[`KBD_TOGGLE_BIT] = ~ps2_key[`KBD_TOGGLE_BIT];  // Marks a new event
        ps2_key[`KBD_MAKE_BIT]   = make;
        ps2_key[`KBD_EXT_BIT]    = ext;
        ps2_key[7:0]             = code;
        wait_decode();
        gap = 1 + ($random(seed) & 3);
        repeat (gap) @(negedge CLK_14M);
    endtask

    task automatic pulse_read();
        @(posedge CLK_14M);
        #2;
        reads = 1'b1;
        @(posedge CLK_14M);
        #2;
        reads = 1'b0;
    endtask

    task automatic expect_strobe(input logic [7:0] expected);
        int n;
        bit raised;
        raised = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !raised; n++)
        begin
            @(negedge CLK_14M);
            raised = k[7];
        end
        if (raised)
            check_value(k, expected, "k");
        else
            report_timeout("k bit 7");
    endtask

    // Strobe must stay low for the whole window
    task automatic expect_quiet(input int cycles);
        int n;
        bit raised;
        raised = 1'b0;
        for (n = 0; n < cycles && !raised; n++)
        begin
            @(negedge CLK_14M);
            raised = k[7];
        end
        check_value(k & 8'h80, 8'h00, "strobe bit");
    endtask

    //----------------------------------------------------------------------
    // Stimulus player
    //----------------------------------------------------------------------
    initial
    begin
        int          idx;
        bit          done;
        logic [15:0] word;
        errors  = 0;
        checks  = 0;
        seed    = 22;
        reset   = 1'b1;
        ps2_key = 11'd0;
        reads   = 1'b0;
        done    = 1'b0;
        $readmemh("tests/kbd_stim.txt", stim_mem);
        repeat (8) @(posedge CLK_14M);
        #2;
        reset = 1'b0;

        for (idx = 0; idx < STIM_DEPTH && !done; idx++)
        begin
            word = stim_mem[idx];
            case (word[15:12])
                4'h1: send_event(1'b1, word[8], word[7:0]);
                4'h2: send_event(1'b0, word[8], word[7:0]);
                4'h3: pulse_read();
                4'h4: expect_strobe(word[7:0]);
                4'h5: check_value({7'd0, akd}, word[7:0], "akd");
                4'h6: check_value({6'd0, open_apple, closed_apple},
                                  {6'd0, word[8], word[0]}, "open and closed apple");
                4'h7: repeat (word[7:0]) @(negedge CLK_14M);
                4'h8: expect_quiet(int'(word[7:0]));
                4'hF: done = 1'b1;
                default:
                begin
                    errors++;
                    $display("Stimulus word %0d holds an unknown operation %h", idx, word);
                    done = 1'b1;
                end
            endcase
        end
        if (!done)
        begin
            errors++;
            $display("The stimulus ran past the end of memory without an end operation");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/kbd_pkg.sv
src/kbd_sequencer.sv
src/repeat_timer.sv
src/modifier_track.sv
src/scan_to_ascii.sv
src/apple_keyboard.sv
tests/tb_apple_keyboard.sv

// File: Makefile
# Verilator flow for the Apple IIe keyboard front end

TOP = tb_apple_keyboard
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/kbd_stim.txt
// Keyboard stimulus, 16-bit hex words: op [15:12], aux [11:8], value [7:0]
// Ops 1 press and 2 release (aux ext, value code), 3 read, 4 expect k, 5 expect akd,
// 6 expect apple (aux open, value closed), 7 idle and 8 quiet (value cycles), F end

// Out of reset
8004 5000 6000

// Plain letter, read, auto-repeat
101C                        // A down
40E1 5001                   // 'a' with strobe, key held
3000 8014                   // Read clears the strobe
40E1 3000                   // Repeat of the same character
201C 5000                   // Release drops akd
803C                        // No repeat once released

// Shifted digit and punctuation
1012                        // Left shift down
1016 40A1 3000 2016         // '!'
104A 40BF 3000 204A         // '?'
2012

// Caps lock flips on each release
1058 2058
1032 40C2 3000 2032         // 'B'
1058 2058
1032 40E2 3000 2032         // 'b' again

// Control code
1014
1021 4083 3000 2021         // Ctrl-C
2014

// Cursor and editing keys
116B 4088 3000 216B         // Left arrow
1174 4095 3000 2174         // Right arrow
1175 408B 3000 2175         // Up arrow
1172 408A 3000 2172         // Down arrow
105A 408D 3000 205A         // Return
1076 409B 3000 2076         // Escape
1066 4088 3000 2066         // Backspace

// F1 has no character
1005 8014 5000 2005

// Apple keys on Windows and Alt
101F 6100 8008              // Open Apple, no strobe
1011 6101
201F 6001
2011 6000

// Held key, unread strobe pauses repeat
1032 40E2 5001
7064 3000                   // Long hold, then read
801E                        // Timer held during the wait
40E2 3000
2032 5000 803C

F000
